// File: compile.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/register_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv_core.sv
tb/wb_rom.sv
tb/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= rtl/rv_pkg.sv rtl/register_file.sv rtl/fetch_stage.sv \
             rtl/decode_stage.sv rtl/execute_stage.sv rtl/rv_core.sv
TB_SRCS   ?= tb/wb_rom.sv tb/tb_rv_core.sv
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(RTL_SRCS) $(TB_SRCS) rtl/rv_consts.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+rtl $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_rv_core.sv
// RV32I core testbench
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module tb_rv_core;
    import rv_pkg::*;

    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_INST = 64;
    localparam int DRAIN_CYCLES    = 24;

    logic        ctrl_clk;
    logic        ctrl_reset;
    ibus_req_t   ibus_req;
    ibus_rsp_t   ibus_rsp;
    retire_t     retire;
    logic        load_en;
    logic [6:0]  load_addr;
    logic [31:0] load_data;
    logic [7:0]  prog_words;
    logic        random_wait;
    logic        ack_hold;
    logic [31:0] prog [$];
    logic [31:0] exp_rd [$];
    logic [31:0] exp_data [$];
    int          cycle_count;
    int          cycle_limit; // Grows as each test starts

    rv_core UUT (
        .ctrl_clk   (ctrl_clk),
        .ctrl_reset (ctrl_reset),
        .ibus_req   (ibus_req),
        .ibus_rsp   (ibus_rsp),
        .retire     (retire)
    );

    wb_rom u_rom (
        .ctrl_clk    (ctrl_clk),
        .ctrl_reset  (ctrl_reset),
        .ibus_req    (ibus_req),
        .ibus_rsp    (ibus_rsp),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .prog_words  (prog_words),
        .random_wait (random_wait),
        .ack_hold    (ack_hold)
    );

    initial ctrl_clk = 1'b0;
    always #20 ctrl_clk = ~ctrl_clk;

    always @(posedge ctrl_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display(">>> FAIL");
            $fatal(1, "Timeout, tests still running after %0d cycles", cycle_count);
        end
    end

    // Instruction encoders
    function automatic logic [31:0] enc_i(input logic [2:0] f3, input int rd, input int rs1,
                                          input logic [31:0] imm, input logic [6:0] opc);
        return {imm[11:0], 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic alt, input int rd,
                                          input int rs1, input int rs2);
        return {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), `RV_OP_REG};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd,
                                          input logic [31:0] upper);
        return {upper[31:12], 5'(rd), opc};
    endfunction

    function automatic logic [31:0] enc_j(input int rd, input logic [31:0] o);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), `RV_OP_JAL};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                          input logic [31:0] o);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] sext12(input logic [31:0] v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b); // Differing signs decide alone
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] s;
        s = b[4:0];
        case (f3)
            `RV_F3_ADD:  return alt ? a - b : a + b;
            `RV_F3_SLL:  return a << s;
            `RV_F3_SLT:  return {31'b0, signed_less(a, b)};
            `RV_F3_SLTU: return {31'b0, a < b};
            `RV_F3_XOR:  return a ^ b;
            `RV_F3_SR:   return alt ? (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'h0)
                                    : a >> s;
            `RV_F3_OR:   return a | b;
            default:     return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            `RV_F3_BEQ:  return a == b;
            `RV_F3_BNE:  return a != b;
            `RV_F3_BLT:  return signed_less(a, b);
            `RV_F3_BGE:  return !signed_less(a, b);
            `RV_F3_BLTU: return a < b;
            `RV_F3_BGEU: return a >= b;
            default:     return 1'b0;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic expect_write(input int rd, input logic [31:0] data);
        exp_rd.push_back(32'(rd));
        exp_data.push_back(data);
    endtask

    task automatic clear_program;
        prog.delete();
        exp_rd.delete();
        exp_data.delete();
    endtask

    // LUI upper part absorbs the sign of the ADDI immediate
    task automatic load_const(input int rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = v + 32'h800;
        upper[11:0] = 12'h0;
        emit(enc_u(`RV_OP_LUI, rd, upper));
        expect_write(rd, upper);
        emit(enc_i(`RV_F3_ADD, rd, rd, v, `RV_OP_IMM));
        expect_write(rd, v);
    endtask

    // Load program under reset, release, then match every retire record
    task automatic run_program(input string name, input logic rand_wait);
        int got;
        cycle_limit += CYCLES_PER_INST * prog.size() + prog.size() + RESET_CYCLES
                       + DRAIN_CYCLES;
        @(posedge ctrl_clk);
        #2;
        ctrl_reset  = 1'b1;
        ack_hold    = 1'b0;
        random_wait = rand_wait;
        prog_words  = 8'(prog.size());
        foreach (prog[i]) begin
            load_en   = 1'b1;
            load_addr = 7'(i);
            load_data = prog[i];
            @(posedge ctrl_clk);
            #2;
        end
        load_en = 1'b0;
        repeat (RESET_CYCLES) @(posedge ctrl_clk);
        #2;
        ctrl_reset = 1'b0;
        got = 0;
        while (got < exp_rd.size()) begin
            @(negedge ctrl_clk);
            if (retire.valid) begin
                check($sformatf("%s retire %0d rd", name, got), exp_rd[got], 32'(retire.rd));
                check($sformatf("%s retire %0d data", name, got), exp_data[got], retire.data);
                got++;
            end
        end
        repeat (DRAIN_CYCLES) begin
            @(negedge ctrl_clk);
            check({name, " retire after program end"}, 32'd0, 32'(retire.valid));
        end
    endtask

    task automatic reset_state_test;
        cycle_limit += RESET_CYCLES + DRAIN_CYCLES + CYCLES_PER_INST;
        @(posedge ctrl_clk);
        #2;
        ctrl_reset = 1'b1;
        ack_hold   = 1'b1;
        prog_words = 8'd0;
        repeat (RESET_CYCLES) @(posedge ctrl_clk);
        @(negedge ctrl_clk);
        check("reset_state cyc in reset", 32'd0, 32'(ibus_req.cyc));
        @(posedge ctrl_clk);
        #2;
        ctrl_reset = 1'b0;
        repeat (12) begin
            @(negedge ctrl_clk);
            check("reset_state retire valid", 32'd0, 32'(retire.valid));
        end
        check("reset_state cyc", 32'd1, 32'(ibus_req.cyc));
        check("reset_state stb", 32'd1, 32'(ibus_req.stb));
        check("reset_state adr", `RV_RESET_PC, ibus_req.adr);
    endtask

    task automatic alu_test;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] upper;
        int          rd;
        clear_program();
        a = $urandom | 32'h8000_0000; // Negative, so signed and unsigned compares differ
        b = ($urandom & 32'h7fff_ffe0) | 32'($urandom_range(31, 1));
        load_const(1, a);
        load_const(2, b);
        rd = 3;
        for (int f = 0; f < 8; f++) begin
            emit(enc_r(3'(f), 1'b0, rd, 1, 2));
            expect_write(rd, alu_ref(3'(f), 1'b0, a, b));
            rd++;
        end
        emit(enc_r(`RV_F3_ADD, 1'b1, rd, 1, 2));
        expect_write(rd, alu_ref(`RV_F3_ADD, 1'b1, a, b));
        rd++;
        emit(enc_r(`RV_F3_SR, 1'b1, rd, 1, 2));
        expect_write(rd, alu_ref(`RV_F3_SR, 1'b1, a, b));
        rd++;
        emit(enc_r(`RV_F3_SLT, 1'b0, rd, 2, 1));
        expect_write(rd, alu_ref(`RV_F3_SLT, 1'b0, b, a));
        rd++;
        emit(enc_r(`RV_F3_SLTU, 1'b0, rd, 2, 1));
        expect_write(rd, alu_ref(`RV_F3_SLTU, 1'b0, b, a));
        rd++;
        for (int f = 0; f < 8; f++) begin
            imm = (f == 1 || f == 5) ? 32'($urandom_range(31, 1)) : $urandom;
            emit(enc_i(3'(f), rd, 1, imm, `RV_OP_IMM));
            expect_write(rd, alu_ref(3'(f), 1'b0, a, sext12(imm)));
            rd++;
        end
        imm = 32'($urandom_range(31, 1));
        emit(enc_i(`RV_F3_SR, rd, 1, 32'h400 | imm, `RV_OP_IMM)); // SRAI
        expect_write(rd, alu_ref(`RV_F3_SR, 1'b1, a, imm));
        rd++;
        upper = $urandom & 32'hffff_f000;
        expect_write(rd, 32'(prog.size() * 4) + upper);
        emit(enc_u(`RV_OP_AUIPC, rd, upper));
        run_program("alu", 1'b0);
    endtask

    task automatic forward_test;
        logic [31:0] step;
        logic [31:0] sum;
        clear_program();
        step = $urandom;
        sum  = 32'd0;
        load_const(6, step);
        emit(enc_i(`RV_F3_ADD, 5, 0, 32'd0, `RV_OP_IMM));
        expect_write(5, 32'd0);
        repeat (6) begin
            emit(enc_r(`RV_F3_ADD, 1'b0, 5, 5, 6));
            sum += step;
            expect_write(5, sum);
        end
        emit(enc_i(`RV_F3_ADD, 0, 6, 32'd1, `RV_OP_IMM)); // Retires, but x0 stays zero
        expect_write(0, step + 32'd1);
        emit(enc_r(`RV_F3_ADD, 1'b0, 7, 0, 6));
        expect_write(7, step);
        emit(enc_r(`RV_F3_ADD, 1'b0, 8, 0, 0));
        expect_write(8, 32'd0);
        emit(enc_r(`RV_F3_ADD, 1'b0, 9, 5, 5));
        expect_write(9, sum + sum);
        run_program("forward", 1'b0);
    endtask

    task automatic branch_test(input string name, input logic rand_wait);
        logic [2:0]  conds [6];
        logic [31:0] pair_a [3];
        logic [31:0] pair_b [3];
        int          id;
        clear_program();
        conds  = '{`RV_F3_BEQ, `RV_F3_BNE, `RV_F3_BLT, `RV_F3_BGE, `RV_F3_BLTU, `RV_F3_BGEU};
        pair_a = '{32'hffff_fffb, 32'd3, 32'd7};
        pair_b = '{32'd3, 32'hffff_fffb, 32'd7};
        id = 1;
        foreach (conds[c]) begin
            for (int p = 0; p < 3; p++) begin
                emit(enc_i(`RV_F3_ADD, 1, 0, pair_a[p], `RV_OP_IMM));
                expect_write(1, pair_a[p]);
                emit(enc_i(`RV_F3_ADD, 2, 0, pair_b[p], `RV_OP_IMM));
                expect_write(2, pair_b[p]);
                emit(enc_b(conds[c], 1, 2, 32'd8));
                emit(enc_i(`RV_F3_ADD, 10, 0, -1, `RV_OP_IMM)); // Skipped when taken
                if (!branch_ref(conds[c], pair_a[p], pair_b[p]))
                    expect_write(10, 32'hffff_ffff);
                emit(enc_i(`RV_F3_ADD, 11, 0, id, `RV_OP_IMM));
                expect_write(11, id);
                id++;
            end
        end
        run_program(name, rand_wait);
    endtask

    task automatic jump_test;
        clear_program();
        emit(enc_j(1, 32'd8));                               // pc 0
        expect_write(1, 32'd4);
        emit(enc_i(`RV_F3_ADD, 10, 0, -1, `RV_OP_IMM));
        emit(enc_i(`RV_F3_ADD, 2, 0, 32'd24, `RV_OP_IMM));   // pc 8
        expect_write(2, 32'd24);
        emit(enc_i(3'b000, 3, 2, 32'd4, `RV_OP_JALR));       // pc 12, to 28
        expect_write(3, 32'd16);
        emit(enc_i(`RV_F3_ADD, 10, 0, -2, `RV_OP_IMM));
        emit(enc_i(`RV_F3_ADD, 10, 0, -3, `RV_OP_IMM));
        emit(enc_i(`RV_F3_ADD, 11, 0, 32'd1, `RV_OP_IMM));
        emit(enc_i(`RV_F3_ADD, 11, 0, 32'd2, `RV_OP_IMM));   // pc 28
        expect_write(11, 32'd2);
        emit(enc_j(5, 32'd12));                              // pc 32, to 44
        expect_write(5, 32'd36);
        emit(enc_i(`RV_F3_ADD, 10, 0, -4, `RV_OP_IMM));
        emit(enc_i(`RV_F3_ADD, 10, 0, -5, `RV_OP_IMM));
        emit(enc_i(`RV_F3_ADD, 12, 5, 32'd1, `RV_OP_IMM));   // pc 44
        expect_write(12, 32'd37);
        emit(enc_i(3'b000, 6, 5, 32'd20, `RV_OP_JALR));      // pc 48, to 56
        expect_write(6, 32'd52);
        emit(enc_i(`RV_F3_ADD, 10, 0, -6, `RV_OP_IMM));
        emit(enc_i(`RV_F3_ADD, 13, 6, 32'd0, `RV_OP_IMM));   // pc 56
        expect_write(13, 32'd52);
        run_program("jump", 1'b0);
    endtask

    initial begin
        void'($urandom(70));
        ctrl_reset  = 1'b1;
        load_en     = 1'b0;
        load_addr   = 7'd0;
        load_data   = 32'd0;
        prog_words  = 8'd0;
        random_wait = 1'b0;
        ack_hold    = 1'b0;
        cycle_count = 0;
        cycle_limit = 0;
        reset_state_test();
        alu_test();
        forward_test();
        branch_test("branch", 1'b0);
        jump_test();
        branch_test("branch_wait_states", 1'b1);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/wb_rom.sv
// Wishbone instruction ROM
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module wb_rom #(
    parameter int DEPTH = 128
) (
    input  wire logic              ctrl_clk,
    input  wire logic              ctrl_reset,
    input  wire rv_pkg::ibus_req_t ibus_req,
    output rv_pkg::ibus_rsp_t      ibus_rsp,
    input  wire logic              load_en,
    input  wire logic [6:0]        load_addr,
    input  wire logic [31:0]       load_data,
    input  wire logic [7:0]        prog_words,
    input  wire logic              random_wait,
    input  wire logic              ack_hold
);
    logic [`RV_XLEN-1:0] mem [0:DEPTH-1];
    logic [1:0]          wait_left; // Extra cycles before the next ack
    logic [`RV_XLEN-1:0] word_idx;

    assign word_idx = ibus_req.adr >> 2;

    always_ff @(posedge ctrl_clk) begin
        if (load_en)
            mem[load_addr] <= load_data;
        if (ctrl_reset) begin
            ibus_rsp.ack <= 1'b0;
            wait_left    <= 2'd0;
        end else if (ibus_rsp.ack) begin
            ibus_rsp.ack <= 1'b0; // One ack per request
            wait_left    <= random_wait ? 2'($urandom_range(2, 0)) : 2'd0;
        end else if (ibus_req.cyc && ibus_req.stb && !ack_hold) begin
            if (wait_left == 2'd0) begin
                ibus_rsp.ack <= 1'b1;
                // Past the program the core sees NOPs
                ibus_rsp.dat <= (word_idx < 32'(prog_words)) ? mem[word_idx[6:0]]
                                                             : `RV_INST_NOP;
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_core.sv
// RV32I three-stage core
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module rv_core (
    input  wire logic              ctrl_clk,
    input  wire logic              ctrl_reset,
    output rv_pkg::ibus_req_t      ibus_req,
    input  wire rv_pkg::ibus_rsp_t ibus_rsp,
    output rv_pkg::retire_t        retire
);
    import rv_pkg::*;

    fetch_out_t            fetch_out;
    exec_op_t              exec_op;
    fwd_t                  fwd;
    redirect_t             redirect;
    logic                  front_stall; // Waiting on instruction bus ack
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;

    fetch_stage u_fetch (
        .ctrl_clk    (ctrl_clk),
        .ctrl_reset  (ctrl_reset),
        .ibus_req    (ibus_req),
        .ibus_rsp    (ibus_rsp),
        .redirect    (redirect),
        .hold        (front_stall),
        .fetch_out   (fetch_out),
        .front_stall (front_stall)
    );

    decode_stage u_decode (
        .ctrl_clk   (ctrl_clk),
        .ctrl_reset (ctrl_reset),
        .hold       (front_stall),
        .fetch_in   (fetch_out),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .fwd        (fwd),
        .redirect   (redirect),
        .exec_op    (exec_op)
    );

    execute_stage u_execute (
        .ctrl_clk   (ctrl_clk),
        .ctrl_reset (ctrl_reset),
        .exec_op    (exec_op),
        .fwd        (fwd),
        .retire     (retire)
    );

    // Retire record doubles as the write port
    register_file u_regs (
        .ctrl_clk (ctrl_clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr       (retire)
    );

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
// RV32I execute stage
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module execute_stage (
    input  wire logic             ctrl_clk,
    input  wire logic             ctrl_reset,
    input  wire rv_pkg::exec_op_t exec_op,
    output rv_pkg::fwd_t          fwd,
    output rv_pkg::retire_t       retire
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] result;
    logic [4:0]          shamt;

    assign shamt = exec_op.op2[4:0];

    always_comb begin
        case (exec_op.alu_func)
            ALU_ADD:  result = exec_op.alt ? exec_op.op1 - exec_op.op2
                                           : exec_op.op1 + exec_op.op2;
            ALU_SLL:  result = exec_op.op1 << shamt;
            ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}},
                                $signed(exec_op.op1) < $signed(exec_op.op2)};
            ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, exec_op.op1 < exec_op.op2};
            ALU_XOR:  result = exec_op.op1 ^ exec_op.op2;
            ALU_SR: begin
                // SRA fills with the sign bit
                if (exec_op.alt)
                    result = $signed(exec_op.op1) >>> shamt;
                else
                    result = exec_op.op1 >> shamt;
            end
            ALU_OR:   result = exec_op.op1 | exec_op.op2;
            ALU_AND:  result = exec_op.op1 & exec_op.op2;
            default:  result = '0;
        endcase
    end

    // x0 never forwards
    assign fwd.valid = exec_op.valid && exec_op.wb && (exec_op.rd != '0);
    assign fwd.rd    = exec_op.rd;
    assign fwd.data  = result;

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset)
            retire.valid <= 1'b0;
        else
            retire.valid <= exec_op.valid && exec_op.wb;
        retire.rd   <= exec_op.rd;
        retire.data <= result;
    end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
// RV32I decode stage
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module decode_stage (
    input  wire logic                  ctrl_clk,
    input  wire logic                  ctrl_reset,
    input  wire logic                  hold,
    input  wire rv_pkg::fetch_out_t    fetch_in,
    output logic [`RV_REG_AW-1:0]      rs1_addr,
    output logic [`RV_REG_AW-1:0]      rs2_addr,
    input  wire logic [`RV_XLEN-1:0]   rs1_data,
    input  wire logic [`RV_XLEN-1:0]   rs2_data,
    input  wire rv_pkg::fwd_t          fwd,
    output rv_pkg::redirect_t          redirect,
    output rv_pkg::exec_op_t           exec_op
);
    import rv_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   imm_i;
    logic [`RV_XLEN-1:0]   imm_u;
    logic [`RV_XLEN-1:0]   imm_j;
    logic [`RV_XLEN-1:0]   imm_b;
    logic [`RV_XLEN-1:0]   rs1_val;
    logic [`RV_XLEN-1:0]   rs2_val;
    logic                  kill;
    logic                  take;
    logic                  issue;
    logic                  known;
    logic                  is_transfer;
    logic                  cond;
    logic [`RV_XLEN-1:0]   target;
    exec_op_t              next_op;

    assign opcode   = fetch_in.inst[6:0];
    assign funct3   = fetch_in.inst[14:12];
    assign rd       = fetch_in.inst[11:7];
    assign rs1_addr = fetch_in.inst[19:15];
    assign rs2_addr = fetch_in.inst[24:20];

    assign imm_i = {{20{fetch_in.inst[31]}}, fetch_in.inst[31:20]};
    assign imm_u = {fetch_in.inst[31:12], 12'b0};
    assign imm_j = {{12{fetch_in.inst[31]}}, fetch_in.inst[19:12], fetch_in.inst[20],
                    fetch_in.inst[30:21], 1'b0};
    assign imm_b = {{20{fetch_in.inst[31]}}, fetch_in.inst[7], fetch_in.inst[30:25],
                    fetch_in.inst[11:8], 1'b0};

    // Execute result wins over the register file
    assign rs1_val = (fwd.valid && fwd.rd == rs1_addr) ? fwd.data : rs1_data;
    assign rs2_val = (fwd.valid && fwd.rd == rs2_addr) ? fwd.data : rs2_data;

    assign take  = fetch_in.valid && !hold;
    assign issue = take && !kill; // Killed slot becomes a bubble

    always_comb begin
        case (funct3)
            `RV_F3_BEQ:  cond = (rs1_val == rs2_val);
            `RV_F3_BNE:  cond = (rs1_val != rs2_val);
            `RV_F3_BLT:  cond = ($signed(rs1_val) < $signed(rs2_val));
            `RV_F3_BGE:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            `RV_F3_BLTU: cond = (rs1_val < rs2_val);
            `RV_F3_BGEU: cond = (rs1_val >= rs2_val);
            default:     cond = 1'b0;
        endcase
    end

    always_comb begin
        known            = 1'b1;
        is_transfer      = 1'b0;
        target           = fetch_in.pc + imm_b;
        next_op.op1      = rs1_val;
        next_op.op2      = rs2_val;
        next_op.rd       = rd;
        next_op.alu_func = ALU_ADD;
        next_op.alt      = 1'b0;
        next_op.wb       = 1'b1;
        case (opcode)
            `RV_OP_LUI: begin
                next_op.op1 = imm_u;
                next_op.op2 = '0;
            end
            `RV_OP_AUIPC: begin
                next_op.op1 = fetch_in.pc;
                next_op.op2 = imm_u;
            end
            `RV_OP_JAL: begin
                next_op.op1 = fetch_in.pc; // Link value pc+4
                next_op.op2 = `RV_XLEN'(4);
                is_transfer = 1'b1;
                target      = fetch_in.pc + imm_j;
            end
            `RV_OP_JALR: begin
                next_op.op1 = fetch_in.pc;
                next_op.op2 = `RV_XLEN'(4);
                is_transfer = 1'b1;
                target      = rs1_val + imm_i;
                target[0]   = 1'b0;
            end
            `RV_OP_BRANCH: begin
                next_op.wb  = 1'b0;
                is_transfer = cond;
            end
            `RV_OP_IMM: begin
                next_op.op2      = imm_i;
                next_op.alu_func = alu_func_e'(funct3);
                next_op.alt      = (funct3 == `RV_F3_SR) && fetch_in.inst[30]; // SRAI only
            end
            `RV_OP_REG: begin
                next_op.alu_func = alu_func_e'(funct3);
                next_op.alt      = fetch_in.inst[30];
            end
            default: begin
                known      = 1'b0;
                next_op.wb = 1'b0;
            end
        endcase
        if (fetch_in.inst == `RV_INST_NOP)
            known = 1'b0;
        next_op.valid = issue && known;
    end

    assign redirect.taken  = issue && known && is_transfer;
    assign redirect.target = target;

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            kill          <= 1'b0;
            exec_op.valid <= 1'b0;
        end else begin
            exec_op.valid <= next_op.valid; // Bubble under hold
            if (take)
                kill <= redirect.taken;
        end
        if (issue) begin
            exec_op.op1      <= next_op.op1;
            exec_op.op2      <= next_op.op2;
            exec_op.rd       <= next_op.rd;
            exec_op.alu_func <= next_op.alu_func;
            exec_op.alt      <= next_op.alt;
            exec_op.wb       <= next_op.wb;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
// RV32I fetch stage
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module fetch_stage (
    input  wire logic              ctrl_clk,
    input  wire logic              ctrl_reset,
    output rv_pkg::ibus_req_t      ibus_req,
    input  wire rv_pkg::ibus_rsp_t ibus_rsp,
    input  wire rv_pkg::redirect_t redirect,
    input  wire logic              hold,
    output rv_pkg::fetch_out_t     fetch_out,
    output logic                   front_stall
);
    typedef enum logic {ST_IDLE, ST_REQ} state_e;

    state_e              state;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] next_pc;
    logic                redir_pending; // Redirect seen before the current ack
    logic [`RV_XLEN-1:0] redir_target;
    logic                accept;

    assign ibus_req.cyc = (state == ST_REQ);
    assign ibus_req.stb = (state == ST_REQ);
    assign ibus_req.adr = pc;

    assign front_stall = (state == ST_REQ) && !ibus_rsp.ack;
    assign accept      = (state == ST_REQ) && ibus_rsp.ack && !hold;

    always_comb begin
        if (redirect.taken)
            next_pc = redirect.target;
        else if (redir_pending)
            next_pc = redir_target;
        else
            next_pc = pc + `RV_XLEN'(4);
    end

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            state           <= ST_IDLE;
            pc              <= `RV_RESET_PC;
            redir_pending   <= 1'b0;
            fetch_out.valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: state <= ST_REQ;
                ST_REQ:  if (ibus_rsp.ack) state <= ST_IDLE; // Bus idles one cycle
                default: state <= ST_IDLE;
            endcase
            if (accept) begin
                pc              <= next_pc;
                redir_pending   <= 1'b0;
                fetch_out.valid <= 1'b1;
            end else begin
                if (!hold)
                    fetch_out.valid <= 1'b0;
                if (redirect.taken)
                    redir_pending <= 1'b1;
            end
        end
        if (accept) begin
            fetch_out.pc   <= pc;
            fetch_out.inst <= ibus_rsp.dat;
        end
        if (redirect.taken)
            redir_target <= redirect.target;
    end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
// RV32I register file
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module register_file (
    input  wire logic                  ctrl_clk,
    input  wire logic [`RV_REG_AW-1:0] rs1_addr,
    input  wire logic [`RV_REG_AW-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]        rs1_data,
    output logic [`RV_XLEN-1:0]        rs2_data,
    input  wire rv_pkg::retire_t       wr
);
    logic [`RV_XLEN-1:0] regs [1:31]; // x0 is not stored

    function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] addr);
        if (addr == '0)
            return '0;
        if (wr.valid && wr.rd == addr) // Write-through
            return wr.data;
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge ctrl_clk) begin
        if (wr.valid && wr.rd != '0)
            regs[wr.rd] <= wr.data;
    end

endmodule

`default_nettype wire

// File: rtl/rv_pkg.sv
// RV32I pipeline types
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

    typedef enum logic [2:0] {
        ALU_ADD  = `RV_F3_ADD,
        ALU_SLL  = `RV_F3_SLL,
        ALU_SLT  = `RV_F3_SLT,
        ALU_SLTU = `RV_F3_SLTU,
        ALU_XOR  = `RV_F3_XOR,
        ALU_SR   = `RV_F3_SR,
        ALU_OR   = `RV_F3_OR,
        ALU_AND  = `RV_F3_AND
    } alu_func_e;

    // Wishbone classic instruction bus
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic [`RV_XLEN-1:0] adr;
    } ibus_req_t;

    typedef struct packed {
        logic                ack;
        logic [`RV_XLEN-1:0] dat;
    } ibus_rsp_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] inst;
    } fetch_out_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   op1;
        logic [`RV_XLEN-1:0]   op2;
        logic [`RV_REG_AW-1:0] rd;
        alu_func_e             alu_func;
        logic                  alt; // SUB or SRA
        logic                  wb;
    } exec_op_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
    } retire_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
    } fwd_t;

    typedef struct packed {
        logic                taken;
        logic [`RV_XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: rtl/rv_consts.svh
// RV32I core constants
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN      32
`define RV_REG_AW    5
`define RV_RESET_PC  32'h0000_0000

// Major opcodes
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011

// ALU funct3
`define RV_F3_ADD   3'b000 // Also SUB
`define RV_F3_SLL   3'b001
`define RV_F3_SLT   3'b010
`define RV_F3_SLTU  3'b011
`define RV_F3_XOR   3'b100
`define RV_F3_SR    3'b101 // SRL and SRA
`define RV_F3_OR    3'b110
`define RV_F3_AND   3'b111

// Branch funct3
`define RV_F3_BEQ   3'b000
`define RV_F3_BNE   3'b001
`define RV_F3_BLT   3'b100
`define RV_F3_BGE   3'b101
`define RV_F3_BLTU  3'b110
`define RV_F3_BGEU  3'b111

`define RV_INST_NOP  32'h0000_0013 // ADDI x0, x0, 0

`endif
